// File: maze_defines.svh
`ifndef MAZE_DEFINES_SVH
`define MAZE_DEFINES_SVH

// Cells per maze side.
`define MAZE_DIM 16

// Bits per coordinate.
`define COORD_W 4

// One memory bit per cell, address is y * MAZE_DIM + x.
`define ADDR_W 8

// Enough entries for a walk through every cell.
`define STACK_DEPTH 256

`endif

// File: maze_pkg.sv
`default_nettype none

`include "maze_defines.svh"

package maze_pkg;

	typedef enum logic [3:0] {
		s_idle,
		s_init,
		s_mark,
		s_probe,
		s_probe_wait,
		s_advance,
		s_next_dir,
		s_backtrack,
		s_drain,
		s_drain_push,
		s_done,
		s_show,
		s_fail
	} ctrl_state_e;

	// Search order.
	typedef enum logic [1:0] {
		dir_east,
		dir_south,
		dir_west,
		dir_north
	} dir_e;

	// y above x, so the packed value is the cell address.
	typedef struct packed {
		logic [`COORD_W-1:0] y;
		logic [`COORD_W-1:0] x;
	} pos_t;

	typedef struct packed {
		logic re;
		logic we;
		logic [`ADDR_W-1:0] addr;
		logic wdata;
	} mem_req_t;

endpackage

`default_nettype wire

// File: maze_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "maze_defines.svh"

module maze_datapath (
	input  logic                CLK,
	input  logic                RST,
	input  logic                init,
	input  logic                en_count,
	input  logic                ldxy,
	input  logic                ld_pos,
	input  logic                use_nbr,
	input  maze_pkg::pos_t      pop_pos,
	output maze_pkg::pos_t      cur_pos,
	output logic [`ADDR_W-1:0] mem_addr,
	output logic                in_bounds,
	output logic                found,
	output logic                co
);
	import maze_pkg::*;

	localparam int addr_w = `ADDR_W;
	localparam logic [`COORD_W-1:0] last_idx = `COORD_W'(`MAZE_DIM - 1);

	dir_e dir;
	pos_t nbr;
	pos_t sel_pos;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cur_pos <= '0;
			dir <= dir_east;
		end else if (init) begin
			cur_pos <= '0;
			dir <= dir_east;
		end else if (ldxy) begin
			cur_pos <= nbr;
			dir <= dir_east; // Fresh cell starts over.
		end else if (ld_pos) begin
			cur_pos <= pop_pos;
			dir <= dir_east;
		end else if (en_count) begin
			dir <= dir_e'(dir + 2'd1);
		end
	end

	always_comb begin
		nbr = cur_pos;
		in_bounds = 1'b0;
		case (dir)
			dir_east: begin
				nbr.x = cur_pos.x + 1'b1;
				in_bounds = (cur_pos.x != last_idx);
			end
			dir_south: begin
				nbr.y = cur_pos.y + 1'b1;
				in_bounds = (cur_pos.y != last_idx);
			end
			dir_west: begin
				nbr.x = cur_pos.x - 1'b1;
				in_bounds = (cur_pos.x != '0);
			end
			default: begin
				nbr.y = cur_pos.y - 1'b1;
				in_bounds = (cur_pos.y != '0);
			end
		endcase
	end

	assign sel_pos = use_nbr ? nbr : cur_pos;
	assign mem_addr = addr_w'(sel_pos.y * `MAZE_DIM + sel_pos.x);
	assign found = (cur_pos.x == last_idx) && (cur_pos.y == last_idx);
	assign co = (dir == dir_north); // Last direction in use.

endmodule

`default_nettype wire

// File: loc_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "maze_defines.svh"

module loc_stack (
	input  logic           CLK,
	input  logic           RST,
	input  logic           clear,
	input  logic           push,
	input  logic           pop,
	input  maze_pkg::pos_t din,
	output maze_pkg::pos_t top,
	output logic           empty
);
	import maze_pkg::*;

	localparam int ptr_w = $clog2(`STACK_DEPTH) + 1;

	pos_t stack_mem [`STACK_DEPTH];
	logic [ptr_w-1:0] ptr;
	logic [ptr_w-2:0] top_idx;

	assign empty = (ptr == '0);
	assign top_idx = ptr[ptr_w-2:0] - 1'b1;
	assign top = stack_mem[top_idx];

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			ptr <= '0;
		end else if (clear) begin
			ptr <= '0;
		end else if (push && (ptr != ptr_w'(`STACK_DEPTH))) begin
			ptr <= ptr + 1'b1;
		end else if (pop && !empty) begin
			ptr <= ptr - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && (ptr != ptr_w'(`STACK_DEPTH))) begin
			stack_mem[ptr[ptr_w-2:0]] <= din;
		end
	end

endmodule

`default_nettype wire

// File: path_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "maze_defines.svh"

module path_list (
	input  logic           CLK,
	input  logic           RST,
	input  logic           clear,
	input  logic           push,
	input  logic           en_read,
	input  logic           run,
	input  maze_pkg::pos_t din,
	output maze_pkg::pos_t path_pos,
	output logic           path_valid,
	output logic           path_last,
	output logic           complete_read
);
	import maze_pkg::*;

	localparam int idx_w = $clog2(`STACK_DEPTH);

	pos_t list_mem [`STACK_DEPTH];
	logic [idx_w:0] count;
	logic [idx_w-1:0] rd_ptr;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			count <= '0;
			rd_ptr <= '0;
		end else begin
			if (clear) begin
				count <= '0;
			end else if (push) begin
				count <= count + 1'b1;
			end
			if (run && !en_read) begin
				rd_ptr <= count[idx_w-1:0] - 1'b1; // Start cell sits highest.
			end else if (en_read && (rd_ptr != '0)) begin
				rd_ptr <= rd_ptr - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !clear) begin
			list_mem[count[idx_w-1:0]] <= din;
		end
	end

	assign path_pos = list_mem[rd_ptr];
	assign complete_read = en_read && (rd_ptr == '0); // Goal at index 0.
	assign path_valid = en_read;
	assign path_last = complete_read;

endmodule

`default_nettype wire

// File: maze_mem_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "maze_defines.svh"

module maze_mem_arb (
	input  logic               CLK,
	input  logic               RST,
	input  maze_pkg::mem_req_t host_req,
	input  maze_pkg::mem_req_t solver_req,
	output logic               host_rdata,
	output logic               solver_rdata,
	output logic               solver_gnt
);
	import maze_pkg::*;

	localparam int cells = `MAZE_DIM * `MAZE_DIM;

	logic maze_mem [cells];
	logic host_act;
	logic solver_rd;
	logic solver_wr;

	assign host_act = host_req.re || host_req.we;
	assign solver_gnt = !host_act; // Host always first.
	assign solver_rd = solver_gnt && solver_req.re;
	assign solver_wr = solver_gnt && solver_req.we;

	always_ff @(posedge CLK) begin
		if (host_req.we) begin
			maze_mem[host_req.addr] <= host_req.wdata;
		end else if (solver_wr) begin
			maze_mem[solver_req.addr] <= solver_req.wdata;
		end
	end

	// Read data holds until the next read on that port.
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			host_rdata <= 1'b0;
			solver_rdata <= 1'b0;
		end else begin
			if (host_req.re) begin
				host_rdata <= maze_mem[host_req.addr];
			end
			if (solver_rd) begin
				solver_rdata <= maze_mem[solver_req.addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: maze_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module maze_ctrl (
	input  logic               CLK,
	input  logic               RST,
	input  logic               start,
	input  logic               run,
	input  logic               found,
	input  logic               in_bounds,
	input  logic               co,
	input  logic               empty,
	input  logic               solver_gnt,
	input  logic               solver_rdata,
	input  logic               complete_read,
	output maze_pkg::mem_req_t solver_req,
	output logic               use_nbr,
	output logic               init,
	output logic               en_count,
	output logic               ldxy,
	output logic               ld_pos,
	output logic               push,
	output logic               pop,
	output logic               list_init,
	output logic               list_push,
	output logic               en_read,
	output logic               busy,
	output logic               done,
	output logic               fail
);
	import maze_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle:       next_state = start ? s_init : s_idle;
			s_init:       next_state = s_mark;
			s_mark:       next_state = !solver_gnt ? s_mark : (found ? s_drain_push : s_probe);
			s_probe:      next_state = !in_bounds ? s_next_dir :
			                           (solver_gnt ? s_probe_wait : s_probe);
			s_probe_wait: next_state = solver_rdata ? s_next_dir : s_advance;
			s_advance:    next_state = s_mark;
			s_next_dir:   next_state = co ? s_backtrack : s_probe;
			s_backtrack:  next_state = empty ? s_fail : s_probe;
			s_drain_push: next_state = s_drain;
			s_drain:      next_state = empty ? s_done : s_drain_push;
			s_done:       next_state = start ? s_init : (run ? s_show : s_done);
			s_show:       next_state = complete_read ? s_done : s_show;
			s_fail:       next_state = start ? s_init : s_fail;
			default:      next_state = s_idle;
		endcase
	end

	always_comb begin
		{use_nbr, init, en_count, ldxy, ld_pos, push, pop} = '0;
		{list_init, list_push, en_read, busy, done, fail} = '0;
		case (state)
			s_init: begin
				init = 1'b1;
				list_init = 1'b1;
				busy = 1'b1;
			end
			s_mark:       busy = 1'b1;
			s_probe: begin
				use_nbr = 1'b1;
				busy = 1'b1;
			end
			s_probe_wait: busy = 1'b1;
			s_advance: begin
				push = 1'b1; // Current cell onto the stack.
				ldxy = 1'b1;
				busy = 1'b1;
			end
			s_next_dir: begin
				en_count = 1'b1;
				busy = 1'b1;
			end
			s_backtrack, s_drain: begin
				pop = 1'b1;
				ld_pos = 1'b1;
				busy = 1'b1;
			end
			s_drain_push: begin
				list_push = 1'b1;
				busy = 1'b1;
			end
			s_done:       done = 1'b1;
			s_show: begin
				en_read = 1'b1;
				done = 1'b1;
			end
			s_fail:       fail = 1'b1;
			default: ;
		endcase
	end

	// Requests stay constant within a state until granted.
	always_comb begin
		solver_req = '0;
		solver_req.we = (state == s_mark);
		solver_req.wdata = (state == s_mark); // Visited.
		solver_req.re = (state == s_probe) && in_bounds;
	end

endmodule

`default_nettype wire

// File: maze_solver_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "maze_defines.svh"

module maze_solver_top (
	input  logic               CLK,
	input  logic               RST,
	input  logic               start,
	input  logic               run,
	input  maze_pkg::mem_req_t host_req,
	output logic               host_rdata,
	output maze_pkg::pos_t     path_pos,
	output logic               path_valid,
	output logic               path_last,
	output logic               busy,
	output logic               done,
	output logic               fail
);
	import maze_pkg::*;

	mem_req_t ctrl_req;
	pos_t cur_pos;
	pos_t stack_top;
	logic [`ADDR_W-1:0] mem_addr;
	logic use_nbr, init, en_count, ldxy, ld_pos, push, pop;
	logic list_init, list_push, en_read, complete_read;
	logic found, in_bounds, co, empty;
	logic solver_gnt, solver_rdata;

	maze_ctrl u_ctrl (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.found(found), .in_bounds(in_bounds), .co(co), .empty(empty),
		.solver_gnt(solver_gnt), .solver_rdata(solver_rdata),
		.complete_read(complete_read), .solver_req(ctrl_req),
		.use_nbr(use_nbr), .init(init), .en_count(en_count), .ldxy(ldxy),
		.ld_pos(ld_pos), .push(push), .pop(pop), .list_init(list_init),
		.list_push(list_push), .en_read(en_read),
		.busy(busy), .done(done), .fail(fail)
	);

	maze_datapath u_datapath (
		.CLK(CLK), .RST(RST), .init(init), .en_count(en_count), .ldxy(ldxy),
		.ld_pos(ld_pos), .use_nbr(use_nbr), .pop_pos(stack_top),
		.cur_pos(cur_pos), .mem_addr(mem_addr),
		.in_bounds(in_bounds), .found(found), .co(co)
	);

	loc_stack u_stack (
		.CLK(CLK), .RST(RST), .clear(init), .push(push), .pop(pop),
		.din(cur_pos), .top(stack_top), .empty(empty)
	);

	// Fed from the position just popped, goal first.
	path_list u_list (
		.CLK(CLK), .RST(RST), .clear(list_init), .push(list_push),
		.en_read(en_read), .run(run), .din(cur_pos), .path_pos(path_pos),
		.path_valid(path_valid), .path_last(path_last),
		.complete_read(complete_read)
	);

	maze_mem_arb u_mem (
		.CLK(CLK), .RST(RST), .host_req(host_req),
		.solver_req({ctrl_req.re, ctrl_req.we, mem_addr, ctrl_req.wdata}),
		.host_rdata(host_rdata), .solver_rdata(solver_rdata),
		.solver_gnt(solver_gnt)
	);

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int half_period = 5
) (
	output logic CLK
);
	initial begin
		CLK = 1'b0;
	end

	always begin
		#half_period;
		CLK = ~CLK; // 10 ns period.
	end

endmodule

`default_nettype wire

// File: maze_solver_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "maze_defines.svh"

module maze_solver_tb;
	import maze_pkg::*;

	localparam int cells = `MAZE_DIM * `MAZE_DIM;
	localparam int max_cycles = 200000;

	logic CLK;
	logic RST;
	logic start;
	logic run;
	mem_req_t host_req;
	logic host_rdata;
	pos_t path_pos;
	logic path_valid;
	logic path_last;
	logic busy;
	logic done;
	logic fail;

	logic maze [cells];
	logic ref_mark [cells]; // Walls plus visited cells.
	int ref_path [$];
	int got_pos [$];
	logic got_last [$];
	int got_cyc [$];
	int errors = 0;
	int cycles = 0;
	int mazes = 0;

	tb_clk_gen clk_gen (.CLK(CLK));

	maze_solver_top UUT (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.host_req(host_req), .host_rdata(host_rdata), .path_pos(path_pos),
		.path_valid(path_valid), .path_last(path_last),
		.busy(busy), .done(done), .fail(fail)
	);

	function automatic int neighbor(input int idx, input int d);
		int x;
		int y;
		x = idx % `MAZE_DIM;
		y = idx / `MAZE_DIM;
		case (d)
			0: x = x + 1; // East.
			1: y = y + 1;
			2: x = x - 1;
			default: y = y - 1;
		endcase
		if (x < 0 || x >= `MAZE_DIM || y < 0 || y >= `MAZE_DIM) begin
			return -1;
		end
		return y * `MAZE_DIM + x;
	endfunction

	// Depth-first walk that never clears a mark.
	function automatic logic solve_ref();
		int stk [$];
		int cur;
		int nxt;
		logic moved;
		for (int i = 0; i < cells; i++) begin
			ref_mark[i] = maze[i];
		end
		ref_path.delete();
		cur = 0;
		ref_mark[0] = 1'b1;
		while (cur != cells - 1) begin
			moved = 1'b0;
			for (int d = 0; d < 4 && !moved; d++) begin
				nxt = neighbor(cur, d);
				if (nxt >= 0 && !ref_mark[nxt]) begin
					stk.push_back(cur);
					cur = nxt;
					ref_mark[cur] = 1'b1;
					moved = 1'b1;
				end
			end
			if (!moved) begin
				if (stk.size() == 0) begin
					return 1'b0;
				end
				cur = stk.pop_back(); // Back to the parent.
			end
		end
		ref_path = stk;
		ref_path.push_back(cur);
		return 1'b1;
	endfunction

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles waiting on done, fail or path_last", cycles);
			$display("Summary: %0d mazes, %0d errors", mazes, errors);
			$display("Testbench failed");
			$finish;
		end
	end

	// Collects replay beats mid-cycle.
	always @(negedge CLK) begin
		if (path_valid) begin
			got_pos.push_back(int'(path_pos));
			got_last.push_back(path_last);
			got_cyc.push_back(cycles);
		end
	end

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic report_value(input string name, input int got, input int exp);
		errors++;
		$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
	endtask

	task automatic fill_maze(input int pct);
		for (int i = 0; i < cells; i++) begin
			maze[i] = (($urandom % 100) < pct);
		end
		maze[0] = 1'b0;
		maze[cells - 1] = 1'b0; // Goal open.
	endtask

	task automatic load_maze();
		for (int i = 0; i < cells; i++) begin
			host_req = '0;
			host_req.we = 1'b1;
			host_req.addr = 8'(i);
			host_req.wdata = maze[i];
			step();
		end
		host_req = '0;
	endtask

	task automatic read_back();
		for (int a = 0; a < cells; a++) begin
			host_req = '0;
			host_req.re = 1'b1;
			host_req.addr = 8'(a);
			step();
			if (host_rdata !== ref_mark[a]) begin
				report_value($sformatf("host_rdata at 0x%0h", a), int'(host_rdata),
					int'(ref_mark[a]));
			end
		end
		host_req = '0;
	endtask

	task automatic run_search(input logic spy);
		int addr;
		got_pos.delete();
		got_last.delete();
		got_cyc.delete();
		start = 1'b1;
		step();
		start = 1'b0;
		if (busy !== 1'b1) begin
			report_value("busy", int'(busy), 1);
		end
		addr = 0;
		while (!(done || fail)) begin
			host_req = '0;
			if (spy && ($urandom % 3 == 0)) begin
				addr = $urandom % cells; // Steals the solver's slot.
				host_req.re = 1'b1;
				host_req.addr = 8'(addr);
			end
			step();
			if (host_req.re && maze[addr] && host_rdata !== 1'b1) begin
				report_value($sformatf("host_rdata at 0x%0h", addr), int'(host_rdata), 1);
			end
		end
		host_req = '0;
	endtask

	task automatic replay_path();
		got_pos.delete();
		got_last.delete();
		got_cyc.delete();
		run = 1'b1;
		step();
		run = 1'b0;
		while (got_last.size() == 0 || !got_last[got_last.size() - 1]) begin
			step();
		end
		repeat (3) step();
		if (done !== 1'b1) begin
			report_value("done", int'(done), 1);
		end
	endtask

	task automatic compare_path();
		if (got_pos.size() != ref_path.size()) begin
			report_value("path length", got_pos.size(), ref_path.size());
		end
		for (int i = 0; i < got_pos.size() && i < ref_path.size(); i++) begin
			if (got_pos[i] != ref_path[i]) begin
				report_value($sformatf("path_pos beat %0d", i), got_pos[i], ref_path[i]);
			end
			if (got_last[i] != (i == ref_path.size() - 1)) begin
				report_value($sformatf("path_last beat %0d", i), int'(got_last[i]),
					int'(i == ref_path.size() - 1));
			end
			if (got_cyc[i] != got_cyc[0] + i) begin
				errors++;
				$display("path_valid was not continuous at beat %0d", i);
			end
		end
	endtask

	task automatic solve_maze(input logic spy, input int replays);
		logic exp_ok;
		mazes++;
		load_maze();
		exp_ok = solve_ref();
		run_search(spy);
		if (done !== exp_ok) begin
			report_value("done", int'(done), int'(exp_ok));
		end
		if (fail !== !exp_ok) begin
			report_value("fail", int'(fail), int'(!exp_ok));
		end
		if (exp_ok && done) begin
			for (int r = 0; r < replays; r++) begin
				replay_path();
				compare_path();
			end
		end else if (!exp_ok) begin
			run = 1'b1;
			step();
			run = 1'b0;
			repeat (`MAZE_DIM * 2) step();
			if (got_pos.size() != 0) begin
				errors++;
				$display("path_valid rose %0d times although the search failed", got_pos.size());
			end
		end
		read_back();
	endtask

	initial begin
		RST = 1'b1;
		start = 1'b0;
		run = 1'b0;
		host_req = '0;
		void'($urandom(64438));
		repeat (5) @(posedge CLK);
		#1;
		RST = 1'b0;
		step();
		fill_maze(0);
		solve_maze(1'b0, 2); // Empty maze replayed twice.
		for (int m = 0; m < 3; m++) begin
			fill_maze(30);
			solve_maze(1'b0, 1);
		end
		fill_maze(0);
		maze[cells - 2] = 1'b1; // Goal walled in.
		maze[cells - 1 - `MAZE_DIM] = 1'b1;
		solve_maze(1'b0, 1);
		fill_maze(25);
		solve_maze(1'b1, 1);
		$display("Summary: %0d mazes, %0d errors", mazes, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
maze_pkg.sv
maze_datapath.sv
loc_stack.sv
path_list.sv
maze_mem_arb.sv
maze_ctrl.sv
maze_solver_top.sv
tb_clk_gen.sv
maze_solver_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module maze_solver_tb -o maze_sim
./obj_dir/maze_sim > sim.log
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi
